/* rtl/cpu_ctrl_pkg.sv */
// cpu control package with field widths and the opcode, funct, regimm, alu, extend and phase enums
package cpu_ctrl_pkg;

    localparam int OPCODE_W = 6;  // instr[31:26]
    localparam int FUNCT_W  = 6;  // instr[5:0]
    localparam int RT_W     = 5;  // instr[20:16], regimm selector
    localparam int ALU_OP_W = 4;  // alu control code
    localparam int EXT_OP_W = 3;  // load data extend code

    // primary opcodes, standard mips encoding
    typedef enum logic [OPCODE_W-1:0] {
        OP_RTYPE  = 6'b000000,  // alu op from funct field
        OP_REGIMM = 6'b000001,  // branch kind from rt field
        OP_J      = 6'b000010,
        OP_JAL    = 6'b000011,
        OP_BEQ    = 6'b000100,
        OP_BNE    = 6'b000101,
        OP_BLEZ   = 6'b000110,
        OP_BGTZ   = 6'b000111,
        OP_ADDIU  = 6'b001001,
        OP_SLTI   = 6'b001010,
        OP_SLTIU  = 6'b001011,
        OP_ANDI   = 6'b001100,
        OP_ORI    = 6'b001101,
        OP_XORI   = 6'b001110,
        OP_LUI    = 6'b001111,
        OP_LB     = 6'b100000,
        OP_LH     = 6'b100001,
        OP_LW     = 6'b100011,
        OP_LBU    = 6'b100100,
        OP_LHU    = 6'b100101,
        OP_SW     = 6'b101011
    } opcode_e;

    // r-type functions handled by the control unit
    typedef enum logic [FUNCT_W-1:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_JR   = 6'b001000,  // jump to rs
        FN_JALR = 6'b001001,  // jump to rs, link into rd
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    // regimm branch selectors in the rt field
    typedef enum logic [RT_W-1:0] {
        RI_BLTZ   = 5'b00000,
        RI_BGEZ   = 5'b00001,
        RI_BLTZAL = 5'b10000,  // links into r31
        RI_BGEZAL = 5'b10001   // links into r31
    } regimm_e;

    // operation codes understood by the alu control block
    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD    = 4'b0000,  // address and addiu add
        ALU_EQ     = 4'b0001,
        ALU_FUNCT  = 4'b0010,  // decode the funct field
        ALU_AND    = 4'b0100,
        ALU_OR     = 4'b0101,
        ALU_XOR    = 4'b0110,
        ALU_SLT    = 4'b0111,
        ALU_NE     = 4'b1000,
        ALU_GTZ    = 4'b1001,
        ALU_LEZ    = 4'b1010,
        ALU_REGIMM = 4'b1011,  // compare kind from rt field
        ALU_SLTU   = 4'b1100
    } alu_op_e;

    // load data extension, msb set means sub-word
    typedef enum logic [EXT_OP_W-1:0] {
        EXT_WORD   = 3'b000,
        EXT_HALF_U = 3'b100,
        EXT_HALF_S = 3'b101,
        EXT_BYTE_U = 3'b110,
        EXT_BYTE_S = 3'b111
    } ext_op_e;

    // instruction phases, code 0 left unused
    typedef enum logic [2:0] {
        ST_FETCH  = 3'd1,  // read instruction at pc
        ST_DECODE = 3'd2,  // latch instruction register
        ST_EXEC1  = 3'd3,  // alu work, data read for loads
        ST_EXEC2  = 3'd4   // write back and pc update
    } ctrl_state_e;

endpackage

/* rtl/instr_decoder.sv */
// instruction decoder turning opcode, funct, rt and phase into datapath controls
`timescale 1ns/1ps

module instr_decoder (
    input  cpu_ctrl_pkg::ctrl_state_e state,
    input  cpu_ctrl_pkg::opcode_e     opcode,
    input  cpu_ctrl_pkg::funct_e      funct,
    input  cpu_ctrl_pkg::regimm_e     rt_code,
    output cpu_ctrl_pkg::alu_op_e     alu_op,
    output cpu_ctrl_pkg::ext_op_e     ext_op,
    output logic                      alu_src,      // immediate as second alu operand
    output logic                      signed_imm,   // sign extend the immediate
    output logic                      jump,
    output logic                      branch,
    output logic                      mem_read,
    output logic                      mem_write,
    output logic                      reg_dst,      // write rd instead of rt
    output logic                      mem_to_reg,
    output logic                      reg_write,
    output logic                      ir_write,
    output logic                      pc_to_addr,   // pc drives the memory address
    output logic                      reg_to_jump,  // jump target from rs
    output logic                      link,         // write return address
    output logic                      load_imm      // lui path
);

    import cpu_ctrl_pkg::*;

    logic exec1;        // data read phase
    logic exec2;        // write back phase
    logic arith_fn;     // funct result goes to rd
    logic reg_jump;     // jr or jalr
    logic regimm_link;  // bltzal or bgezal
    logic wr_req;       // instruction writes the register file
    logic rd_req;       // instruction reads data memory
    logic st_req;       // instruction writes data memory

    assign exec1 = (state == ST_EXEC1);
    assign exec2 = (state == ST_EXEC2);

    assign arith_fn = funct inside {FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV,
                                    FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR,
                                    FN_SLT, FN_SLTU, FN_JALR};
    assign reg_jump    = funct inside {FN_JR, FN_JALR};
    assign regimm_link = rt_code inside {RI_BLTZAL, RI_BGEZAL};

    always_comb begin
        alu_op      = ALU_ADD;
        ext_op      = EXT_WORD;
        alu_src     = 1'b0;
        signed_imm  = 1'b0;
        jump        = 1'b0;
        branch      = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        reg_dst     = 1'b0;
        mem_to_reg  = 1'b0;
        reg_write   = 1'b0;
        ir_write    = 1'b0;
        pc_to_addr  = 1'b0;
        reg_to_jump = 1'b0;
        link        = 1'b0;
        load_imm    = 1'b0;
        wr_req      = 1'b0;
        rd_req      = 1'b0;
        st_req      = 1'b0;

        case (state)
            ST_FETCH: begin
                mem_read   = 1'b1;  // instruction read at pc
                pc_to_addr = 1'b1;
            end
            ST_DECODE: begin
                ir_write   = 1'b1;  // capture returned instruction
                pc_to_addr = 1'b1;
            end
            ST_EXEC1, ST_EXEC2: begin
                case (opcode)
                    OP_RTYPE: begin
                        alu_op      = ALU_FUNCT;
                        reg_dst     = 1'b1;
                        jump        = reg_jump;
                        reg_to_jump = reg_jump;
                        link        = (funct == FN_JALR);
                        wr_req      = arith_fn;
                    end
                    OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_SLTIU: begin
                        alu_src    = 1'b1;
                        signed_imm = (opcode == OP_SLTI);
                        wr_req     = 1'b1;
                        case (opcode)
                            OP_ANDI:  alu_op = ALU_AND;
                            OP_ORI:   alu_op = ALU_OR;
                            OP_XORI:  alu_op = ALU_XOR;
                            OP_SLTI:  alu_op = ALU_SLT;
                            OP_SLTIU: alu_op = ALU_SLTU;
                            default:  alu_op = ALU_ADD;  // addiu
                        endcase
                    end
                    OP_LUI: begin
                        alu_src  = 1'b1;
                        load_imm = 1'b1;  // immediate shifted into upper half
                        wr_req   = 1'b1;
                    end
                    OP_BEQ: begin
                        alu_op = ALU_EQ;
                        branch = 1'b1;
                    end
                    OP_BNE: begin
                        alu_op = ALU_NE;
                        branch = 1'b1;
                    end
                    OP_BGTZ: begin
                        alu_op  = ALU_GTZ;
                        alu_src = 1'b1;
                        branch  = 1'b1;
                    end
                    OP_BLEZ: begin
                        alu_op  = ALU_LEZ;
                        alu_src = 1'b1;
                        branch  = 1'b1;
                    end
                    OP_REGIMM: begin
                        alu_op  = ALU_REGIMM;
                        alu_src = 1'b1;
                        branch  = 1'b1;
                        link    = regimm_link;  // return address to r31
                        wr_req  = regimm_link;
                    end
                    OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
                        alu_src    = 1'b1;  // base plus offset
                        mem_to_reg = (opcode == OP_LW);
                        rd_req     = 1'b1;
                        wr_req     = 1'b1;
                        case (opcode)
                            OP_LB:   ext_op = EXT_BYTE_S;
                            OP_LBU:  ext_op = EXT_BYTE_U;
                            OP_LH:   ext_op = EXT_HALF_S;
                            OP_LHU:  ext_op = EXT_HALF_U;
                            default: ext_op = EXT_WORD;
                        endcase
                    end
                    OP_SW: begin
                        alu_src = 1'b1;
                        reg_dst = 1'b1;
                        st_req  = 1'b1;
                    end
                    OP_J: begin
                        jump = 1'b1;
                    end
                    OP_JAL: begin
                        jump   = 1'b1;
                        link   = 1'b1;
                        wr_req = 1'b1;
                    end
                    default: ;  // unknown opcode keeps every control low
                endcase

                // writes and data reads only in their own phase
                reg_write = wr_req & exec2;
                mem_read  = rd_req & exec1;
                mem_write = st_req & exec2;
            end
            default: ;
        endcase
    end

endmodule

/* rtl/state_sequencer.sv */
// phase sequencer stepping fetch, decode and execute under bus waitrequest
`timescale 1ns/1ps

module state_sequencer (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      waitrequest,  // avalon back-pressure
    input  logic                      mem_read,     // data read pending in exec1
    output cpu_ctrl_pkg::ctrl_state_e state,
    output logic                      pc_write
);

    import cpu_ctrl_pkg::*;

    ctrl_state_e state_nxt;
    logic        bus_busy;  // current phase still waits on the bus

    // fetch and exec2 always hold a bus transfer, exec1 only for loads
    always_comb begin
        case (state)
            ST_FETCH: bus_busy = waitrequest;
            ST_EXEC1: bus_busy = mem_read & waitrequest;
            ST_EXEC2: bus_busy = waitrequest;
            default:  bus_busy = 1'b0;  // decode never waits
        endcase
    end

    always_comb begin
        state_nxt = state;
        if (!bus_busy) begin
            case (state)
                ST_FETCH:  state_nxt = ST_DECODE;
                ST_DECODE: state_nxt = ST_EXEC1;
                ST_EXEC1:  state_nxt = ST_EXEC2;
                ST_EXEC2:  state_nxt = ST_FETCH;
                default:   state_nxt = ST_FETCH;  // recover from an unused code
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_FETCH;
        end else begin
            state <= state_nxt;
        end
    end

    // pc moves once per instruction as exec2 completes
    assign pc_write = (state == ST_EXEC2) & ~waitrequest;

endmodule

/* rtl/cpu_control.sv */
// top level of the multicycle cpu control unit, decoder plus phase sequencer
`timescale 1ns/1ps

module cpu_control (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      waitrequest,  // memory bus stall
    input  cpu_ctrl_pkg::opcode_e     opcode,
    input  cpu_ctrl_pkg::funct_e      funct,
    input  cpu_ctrl_pkg::regimm_e     rt_code,
    output cpu_ctrl_pkg::alu_op_e     alu_op,
    output cpu_ctrl_pkg::ext_op_e     ext_op,
    output cpu_ctrl_pkg::ctrl_state_e state,
    output logic                      alu_src,
    output logic                      signed_imm,
    output logic                      jump,
    output logic                      branch,
    output logic                      mem_read,
    output logic                      mem_write,
    output logic                      reg_dst,
    output logic                      mem_to_reg,
    output logic                      reg_write,
    output logic                      ir_write,
    output logic                      pc_to_addr,
    output logic                      pc_write,
    output logic                      reg_to_jump,
    output logic                      link,
    output logic                      load_imm
);

    // combinational decode of the current instruction and phase
    instr_decoder u_decoder (
        .state       (state),
        .opcode      (opcode),
        .funct       (funct),
        .rt_code     (rt_code),
        .alu_op      (alu_op),
        .ext_op      (ext_op),
        .alu_src     (alu_src),
        .signed_imm  (signed_imm),
        .jump        (jump),
        .branch      (branch),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .reg_dst     (reg_dst),
        .mem_to_reg  (mem_to_reg),
        .reg_write   (reg_write),
        .ir_write    (ir_write),
        .pc_to_addr  (pc_to_addr),
        .reg_to_jump (reg_to_jump),
        .link        (link),
        .load_imm    (load_imm)
    );

    // mem_read loops back so exec1 waits only on loads
    state_sequencer u_sequencer (
        .clk         (clk),
        .arst_n      (arst_n),
        .waitrequest (waitrequest),
        .mem_read    (mem_read),
        .state       (state),
        .pc_write    (pc_write)
    );

endmodule

/* include/tb_vectors.svh */
// instruction rows with expected static controls and per-phase bus and write enables
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef struct packed {
    cpu_ctrl_pkg::opcode_e opcode;
    cpu_ctrl_pkg::funct_e  funct;
    cpu_ctrl_pkg::regimm_e rt_code;
    cpu_ctrl_pkg::alu_op_e alu_op;
    cpu_ctrl_pkg::ext_op_e ext_op;
    // alu_src, signed_imm, jump, branch, reg_dst, mem_to_reg, reg_to_jump, link, load_imm
    logic [8:0]            flags;
    logic [1:0]            reg_write;  // {exec2, exec1}
    logic [1:0]            mem_read;   // {exec2, exec1}
    logic [1:0]            mem_write;  // {exec2, exec1}
} tb_vec_t;

localparam tb_vec_t TB_VECTORS [28] = '{
    '{OP_RTYPE, FN_ADDU, RI_BLTZ, ALU_FUNCT, EXT_WORD, 9'b000010000, 2'b10, 2'b00, 2'b00},
    '{OP_RTYPE, FN_SLL, RI_BLTZ, ALU_FUNCT, EXT_WORD, 9'b000010000, 2'b10, 2'b00, 2'b00},
    '{OP_RTYPE, FN_SLTU, RI_BLTZ, ALU_FUNCT, EXT_WORD, 9'b000010000, 2'b10, 2'b00, 2'b00},
    '{OP_RTYPE, FN_JR, RI_BLTZ, ALU_FUNCT, EXT_WORD, 9'b001010100, 2'b00, 2'b00, 2'b00},
    '{OP_RTYPE, FN_JALR, RI_BLTZ, ALU_FUNCT, EXT_WORD, 9'b001010110, 2'b10, 2'b00, 2'b00},
    '{OP_ADDIU, FN_SLL, RI_BLTZ, ALU_ADD, EXT_WORD, 9'b100000000, 2'b10, 2'b00, 2'b00},
    '{OP_ANDI, FN_SLL, RI_BLTZ, ALU_AND, EXT_WORD, 9'b100000000, 2'b10, 2'b00, 2'b00},
    '{OP_ORI, FN_SLL, RI_BLTZ, ALU_OR, EXT_WORD, 9'b100000000, 2'b10, 2'b00, 2'b00},
    '{OP_XORI, FN_SLL, RI_BLTZ, ALU_XOR, EXT_WORD, 9'b100000000, 2'b10, 2'b00, 2'b00},
    '{OP_SLTI, FN_SLL, RI_BLTZ, ALU_SLT, EXT_WORD, 9'b110000000, 2'b10, 2'b00, 2'b00},
    '{OP_SLTIU, FN_SLL, RI_BLTZ, ALU_SLTU, EXT_WORD, 9'b100000000, 2'b10, 2'b00, 2'b00},
    '{OP_LUI, FN_SLL, RI_BLTZ, ALU_ADD, EXT_WORD, 9'b100000001, 2'b10, 2'b00, 2'b00},
    '{OP_BEQ, FN_SLL, RI_BLTZ, ALU_EQ, EXT_WORD, 9'b000100000, 2'b00, 2'b00, 2'b00},
    '{OP_BNE, FN_SLL, RI_BLTZ, ALU_NE, EXT_WORD, 9'b000100000, 2'b00, 2'b00, 2'b00},
    '{OP_BGTZ, FN_SLL, RI_BLTZ, ALU_GTZ, EXT_WORD, 9'b100100000, 2'b00, 2'b00, 2'b00},
    '{OP_BLEZ, FN_SLL, RI_BLTZ, ALU_LEZ, EXT_WORD, 9'b100100000, 2'b00, 2'b00, 2'b00},
    '{OP_REGIMM, FN_SLL, RI_BLTZ, ALU_REGIMM, EXT_WORD, 9'b100100000, 2'b00, 2'b00, 2'b00},
    '{OP_REGIMM, FN_SLL, RI_BLTZAL, ALU_REGIMM, EXT_WORD, 9'b100100010, 2'b10, 2'b00, 2'b00},
    '{OP_REGIMM, FN_SLL, RI_BGEZAL, ALU_REGIMM, EXT_WORD, 9'b100100010, 2'b10, 2'b00, 2'b00},
    '{OP_LB, FN_SLL, RI_BLTZ, ALU_ADD, EXT_BYTE_S, 9'b100000000, 2'b10, 2'b01, 2'b00},
    '{OP_LBU, FN_SLL, RI_BLTZ, ALU_ADD, EXT_BYTE_U, 9'b100000000, 2'b10, 2'b01, 2'b00},
    '{OP_LH, FN_SLL, RI_BLTZ, ALU_ADD, EXT_HALF_S, 9'b100000000, 2'b10, 2'b01, 2'b00},
    '{OP_LHU, FN_SLL, RI_BLTZ, ALU_ADD, EXT_HALF_U, 9'b100000000, 2'b10, 2'b01, 2'b00},
    '{OP_LW, FN_SLL, RI_BLTZ, ALU_ADD, EXT_WORD, 9'b100001000, 2'b10, 2'b01, 2'b00},
    '{OP_SW, FN_SLL, RI_BLTZ, ALU_ADD, EXT_WORD, 9'b100010000, 2'b00, 2'b00, 2'b10},
    '{OP_J, FN_SLL, RI_BLTZ, ALU_ADD, EXT_WORD, 9'b001000000, 2'b00, 2'b00, 2'b00},
    '{OP_JAL, FN_SLL, RI_BLTZ, ALU_ADD, EXT_WORD, 9'b001000010, 2'b10, 2'b00, 2'b00},
    '{opcode_e'(6'b111111), FN_SLL, RI_BLTZ, ALU_ADD, EXT_WORD, 9'b000000000,
      2'b00, 2'b00, 2'b00}
};

`endif

/* tests/tb_cpu_control.sv */
// testbench for cpu_control with clock, reset, table loop, random stalls, checks and timeout
`timescale 1ns/1ps

module tb_cpu_control;

    import cpu_ctrl_pkg::*;

    `include "tb_vectors.svh"

    localparam int NUM_ROWS       = $size(TB_VECTORS);
    localparam int NUM_PASSES     = 2;  // one pass without stalls, one with
    localparam int MAX_STALL      = 3;
    localparam int TIMEOUT_CYCLES = NUM_PASSES * NUM_ROWS * (4 + 3 * MAX_STALL) + 20;

    logic        clk;
    logic        arst_n;
    logic        waitrequest;
    opcode_e     opcode;
    funct_e      funct;
    regimm_e     rt_code;
    alu_op_e     alu_op;
    ext_op_e     ext_op;
    ctrl_state_e state;
    logic        alu_src, signed_imm, jump, branch, mem_read, mem_write, reg_dst;
    logic        mem_to_reg, reg_write, ir_write, pc_to_addr, pc_write, reg_to_jump;
    logic        link, load_imm;
    int          cycle_count;

    // same order as the flags field of a table row, msb first
    string flag_names [9] = '{"alu_src", "signed_imm", "jump", "branch", "reg_dst",
                              "mem_to_reg", "reg_to_jump", "link", "load_imm"};

    cpu_control dut (
        .clk(clk), .arst_n(arst_n), .waitrequest(waitrequest),
        .opcode(opcode), .funct(funct), .rt_code(rt_code),
        .alu_op(alu_op), .ext_op(ext_op), .state(state),
        .alu_src(alu_src), .signed_imm(signed_imm), .jump(jump), .branch(branch),
        .mem_read(mem_read), .mem_write(mem_write), .reg_dst(reg_dst),
        .mem_to_reg(mem_to_reg), .reg_write(reg_write), .ir_write(ir_write),
        .pc_to_addr(pc_to_addr), .pc_write(pc_write), .reg_to_jump(reg_to_jump),
        .link(link), .load_imm(load_imm)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;  // 20 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, the instruction table did not finish in %0d cycles",
                     TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            $display("MISMATCH at %0t: %s expected 0x%0h actual 0x%0h",
                     $time, name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "stopping at the first wrong value");
        end
    endtask

    task automatic check_reset();
        check_value("state", int'(ST_FETCH), int'(state));
        check_value("mem_read", 1, int'(mem_read));
        check_value("pc_to_addr", 1, int'(pc_to_addr));
        check_value("mem_write", 0, int'(mem_write));
        check_value("reg_write", 0, int'(reg_write));
        check_value("ir_write", 0, int'(ir_write));
        check_value("pc_write", 0, int'(pc_write));
    endtask

    // expected outputs come from the phase rules and the table row
    task automatic check_outputs(input ctrl_state_e ph, input tb_vec_t v);
        logic       exec;
        logic       ex2;
        logic [8:0] exp_flags;
        logic [8:0] act_flags;
        exec      = (ph == ST_EXEC1) || (ph == ST_EXEC2);
        ex2       = (ph == ST_EXEC2);
        exp_flags = exec ? v.flags : 9'b0;
        act_flags = {alu_src, signed_imm, jump, branch, reg_dst,
                     mem_to_reg, reg_to_jump, link, load_imm};
        check_value("state", int'(ph), int'(state));
        check_value("alu_op", exec ? int'(v.alu_op) : int'(ALU_ADD), int'(alu_op));
        check_value("ext_op", exec ? int'(v.ext_op) : int'(EXT_WORD), int'(ext_op));
        for (int i = 0; i < 9; i++) begin
            check_value(flag_names[i], int'(exp_flags[8-i]), int'(act_flags[8-i]));
        end
        check_value("mem_read", int'(exec ? v.mem_read[ex2] : (ph == ST_FETCH)),
                    int'(mem_read));
        check_value("mem_write", int'(exec ? v.mem_write[ex2] : 1'b0), int'(mem_write));
        check_value("reg_write", int'(exec ? v.reg_write[ex2] : 1'b0), int'(reg_write));
        check_value("ir_write", int'(ph == ST_DECODE), int'(ir_write));
        check_value("pc_to_addr", int'((ph == ST_FETCH) || (ph == ST_DECODE)),
                    int'(pc_to_addr));
        check_value("pc_write", int'(ex2 && !waitrequest), int'(pc_write));
    endtask

    // entered just after the edge that put the DUT into phase ph
    task automatic run_phase(input ctrl_state_e ph, input tb_vec_t v, input bit stall_on);
        bit waits;
        int stalls;
        waits  = (ph == ST_FETCH) || (ph == ST_EXEC2) || (ph == ST_EXEC1 && v.mem_read[0]);
        stalls = (stall_on && waits) ? int'($urandom % (MAX_STALL + 1)) : 0;
        for (int c = 0; c <= stalls; c++) begin
            #2;
            opcode  = v.opcode;
            funct   = v.funct;
            rt_code = v.rt_code;
            if (waits) begin
                waitrequest = (c < stalls);  // low on the last cycle completes the transfer
            end else begin
                waitrequest = stall_on ? (($urandom % 2) != 0) : 1'b0;  // must be ignored
            end
            @(negedge clk);
            check_outputs(ph, v);
            @(posedge clk);
        end
    endtask

    task automatic run_instr(input tb_vec_t v, input bit stall_on);
        run_phase(ST_FETCH, v, stall_on);
        run_phase(ST_DECODE, v, stall_on);
        run_phase(ST_EXEC1, v, stall_on);
        run_phase(ST_EXEC2, v, stall_on);
    endtask

    initial begin
        void'($urandom(92));
        cycle_count = 0;
        arst_n      = 1'b0;
        waitrequest = 1'b1;  // keeps fetch waiting right after release
        opcode      = OP_RTYPE;
        funct       = FN_SLL;
        rt_code     = RI_BLTZ;

        @(negedge clk);
        check_reset();  // values while arst_n is still low
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;
        @(negedge clk);
        check_reset();
        @(posedge clk);

        for (int p = 0; p < NUM_PASSES; p++) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                run_instr(TB_VECTORS[r], p == 1);
            end
        end

        #2;
        waitrequest = 1'b1;
        @(negedge clk);
        check_value("state", int'(ST_FETCH), int'(state));  // back to fetch after last row

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* compile.f */
+incdir+include
rtl/cpu_ctrl_pkg.sv
rtl/instr_decoder.sv
rtl/state_sequencer.sv
rtl/cpu_control.sv
tests/tb_cpu_control.sv

/* run_sim.sh */
#!/bin/sh
# Build the cpu_control testbench with Verilator and run it.
# The exit status is the simulator's: nonzero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
    -f compile.f \
    --top-module tb_cpu_control \
    -o tb_cpu_control \
    && ./obj_dir/tb_cpu_control \
    || { echo "build or simulation failed"; exit 1; }
